//--- Makefile
TOP = tb_lv_core
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- files.f
lv_pkg.sv
gnrl_sync.sv
lv_fault_filter.sv
lv_ctrl_unit.sv
lv_reg_slv.sv
lv_core.sv
tb_lv_core.sv

//--- gnrl_sync.sv
// payload bits are resynchronized independently, so multi-bit groups must not rely on coherence
`timescale 1ns/10ps
`default_nettype none

module gnrl_sync #(
    parameter type T      = logic,
    parameter int  STAGES = 2
)(
    input  logic i_clk,
    input  logic i_reset,
    input  T     i_data,
    output T     o_data
);

    T sync_q [STAGES];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= i_data;    // first stage may go metastable
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign o_data = sync_q[STAGES-1];

endmodule

`default_nettype wire

//--- lv_core.sv
// all pin inputs are asynchronous and take SYNC_STAGES cycles to reach the core logic
`timescale 1ns/10ps
`default_nettype none

module lv_core #(
    parameter int REG_AW      = lv_pkg::REG_AW,
    parameter int REG_DW      = lv_pkg::REG_DW,
    parameter int FLT_W       = lv_pkg::FLT_W,
    parameter int SYNC_STAGES = lv_pkg::SYNC_STAGES
)(
    input  logic              i_clk,
    input  logic              i_reset,

    input  logic              i_reg_wr_req,
    input  logic              i_reg_rd_req,
    input  logic [REG_AW-1:0] i_reg_addr,
    input  logic [REG_DW-1:0] i_reg_wdata,
    output logic              o_reg_ack,
    output logic [REG_DW-1:0] o_reg_rdata,

    input  logic              i_lv_pwm_dt,
    input  logic              i_lv_gate_vs_pwm,
    input  logic              i_lv_vsup_ov,
    input  logic              i_lv_vsup_uv_n,

    input  logic              i_io_pwm,
    input  logic              i_io_pwma,
    input  logic              i_io_fsstate,
    input  logic              i_io_fsenb_n,

    output logic              o_dgt_ang_pwm_en,
    output logic              o_dgt_ang_fsc_en,
    output logic              o_intb_n
);

    import lv_pkg::*;

    // field order gives the STATUS2 bit layout
    typedef struct packed {
        logic fsenb_n;
        logic fsstate;
        logic pwma;
        logic pwm;
    } io_pins_t;

    typedef struct packed {
        logic ov;
        logic uv_n;
    } supply_t;

    typedef struct packed {
        logic dt;
        logic gate_vs_pwm;
    } pwm_flt_t;

    io_pins_t         io_pins;
    supply_t          supply;
    pwm_flt_t         pwm_flt;
    logic             dt_err;
    logic             mm_err;
    logic [ERR_NUM-1:0] err_set;
    logic [FLT_W-1:0] flt_thr;
    logic             nml_en;
    logic             cfg_en;
    logic             rst_en;
    logic             fault;
    ctrl_st_e         cur_st;

    //====================
    // pin synchronizers
    //====================
    gnrl_sync #(.T(io_pins_t), .STAGES(SYNC_STAGES)) u_io_sync (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_data  ('{fsenb_n: i_io_fsenb_n, fsstate: i_io_fsstate,
                    pwma: i_io_pwma, pwm: i_io_pwm}),
        .o_data  (io_pins)
    );

    gnrl_sync #(.T(supply_t), .STAGES(SYNC_STAGES)) u_supply_sync (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_data  ('{ov: i_lv_vsup_ov, uv_n: i_lv_vsup_uv_n}),
        .o_data  (supply)
    );

    gnrl_sync #(.T(pwm_flt_t), .STAGES(SYNC_STAGES)) u_pwm_flt_sync (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_data  ('{dt: i_lv_pwm_dt, gate_vs_pwm: i_lv_gate_vs_pwm}),
        .o_data  (pwm_flt)
    );

    //====================
    // fault filters
    //====================
    lv_fault_filter #(.FLT_W(FLT_W)) u_dt_filter (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_fault_raw (pwm_flt.dt),
        .i_thr       (flt_thr),
        .o_fault     (dt_err)
    );

    lv_fault_filter #(.FLT_W(FLT_W)) u_mm_filter (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_fault_raw (pwm_flt.gate_vs_pwm),
        .i_thr       (flt_thr),
        .o_fault     (mm_err)
    );

    // access error is raised inside the register slave
    assign err_set[ERR_ACC] = 1'b0;
    assign err_set[ERR_DT]  = dt_err;
    assign err_set[ERR_MM]  = mm_err;
    assign err_set[ERR_UV]  = ~supply.uv_n;
    assign err_set[ERR_OV]  = supply.ov;

    lv_reg_slv #(.REG_AW(REG_AW), .REG_DW(REG_DW), .FLT_W(FLT_W)) u_reg_slv (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_reg_wr_req (i_reg_wr_req),
        .i_reg_rd_req (i_reg_rd_req),
        .i_reg_addr   (i_reg_addr),
        .i_reg_wdata  (i_reg_wdata),
        .o_reg_ack    (o_reg_ack),
        .o_reg_rdata  (o_reg_rdata),
        .i_err_set    (err_set),
        .i_io_status  (io_pins),
        .i_cur_st     (cur_st),
        .o_flt_thr    (flt_thr),
        .o_nml_en     (nml_en),
        .o_cfg_en     (cfg_en),
        .o_rst_en     (rst_en),
        .o_fault      (fault),
        .o_intb_n     (o_intb_n)
    );

    lv_ctrl_unit u_ctrl_unit (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_nml_en     (nml_en),
        .i_cfg_en     (cfg_en),
        .i_rst_en     (rst_en),
        .i_fault      (fault),
        .i_io_fsenb_n (io_pins.fsenb_n),
        .o_cur_st     (cur_st),
        .o_pwm_en     (o_dgt_ang_pwm_en),
        .o_fsc_en     (o_dgt_ang_fsc_en)
    );

endmodule

`default_nettype wire

//--- lv_core_input.txt
# op and hex fields: W addr data | R addr expected | P pins | D cycles | O pwm_en fsc_en intb_n | T name
# pin bits 7..0: uv_n ov gate_vs_pwm pwm_dt fsenb_n fsstate pwma pwm
T reset_values
R 1 04
R 2 00
R 5 01
R 3 08
W 3 08
R 3 00
W 1 06
R 1 04
W 0 02
D 8
R 5 02
W 1 06
R 1 06
W 2 10
R 2 10
O 0 0 1
T access_error
R 9 00
D 2
O 0 0 0
R 3 01
W 3 01
D 2
R 3 00
O 0 0 1
T normal_mode
W 0 01
D 8
R 5 03
O 1 0 1
P 8d
D 8
R 4 0d
T unmasked_fault
P a8
D 4
P 88
D 8
R 3 00
O 1 0 1
P a8
D 0c
P 88
D 8
R 3 04
R 5 04
O 0 1 0
W 0 04
D 8
R 5 01
O 0 0 0
W 3 04
D 2
O 0 0 1
T masked_fault_fsenb
W 0 02
D 8
R 5 02
W 0 01
D 8
R 5 03
R 2 10
P c8
D 8
R 3 10
O 1 0 0
R 5 03
P 80
D 8
R 5 04
O 0 1 0

//--- lv_ctrl_unit.sv
// fail-safe is left only through reset_en; fault and fsenb_n are acted on in normal state only
`timescale 1ns/10ps
`default_nettype none

module lv_ctrl_unit (
    input  logic             i_clk,
    input  logic             i_reset,

    input  logic             i_nml_en,
    input  logic             i_cfg_en,
    input  logic             i_rst_en,

    input  logic             i_fault,
    input  logic             i_io_fsenb_n,    // synchronized, low forces fail-safe

    output lv_pkg::ctrl_st_e o_cur_st,
    output logic             o_pwm_en,
    output logic             o_fsc_en
);

    import lv_pkg::*;

    ctrl_st_e st_q;
    ctrl_st_e st_nxt;
    logic     pwm_en_q;
    logic     fsc_en_q;

    //====================
    // next state
    //====================
    always_comb begin
        st_nxt = st_q;
        if (i_rst_en) begin
            st_nxt = WAIT_ST;    // soft reset wins from any state
        end else begin
            case (st_q)
                WAIT_ST: begin
                    if (i_cfg_en) begin
                        st_nxt = CFG_ST;
                    end
                end
                CFG_ST: begin
                    if (i_nml_en && !i_cfg_en) begin
                        st_nxt = NML_ST;
                    end
                end
                NML_ST: begin
                    if (i_fault || !i_io_fsenb_n) begin
                        st_nxt = FSF_ST;
                    end
                end
                FSF_ST: begin
                    st_nxt = FSF_ST;
                end
                default: begin
                    st_nxt = WAIT_ST;    // unused code
                end
            endcase
        end
    end

    //====================
    // state and enables
    //====================
    // enables come from next state so they switch with st_q
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            st_q     <= WAIT_ST;
            pwm_en_q <= 1'b0;
            fsc_en_q <= 1'b0;
        end else begin
            st_q     <= st_nxt;
            pwm_en_q <= (st_nxt == NML_ST);
            fsc_en_q <= (st_nxt == FSF_ST);
        end
    end

    assign o_cur_st = st_q;
    assign o_pwm_en = pwm_en_q;
    assign o_fsc_en = fsc_en_q;

endmodule

`default_nettype wire

//--- lv_fault_filter.sv
// input must already be synchronized; a threshold of zero behaves as one
`timescale 1ns/10ps
`default_nettype none

module lv_fault_filter #(
    parameter int FLT_W = lv_pkg::FLT_W
)(
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_fault_raw,
    input  logic [FLT_W-1:0] i_thr,
    output logic             o_fault
);

    logic [FLT_W-1:0] cnt_q;
    logic [FLT_W-1:0] cnt_nxt;
    logic [FLT_W-1:0] thr_eff;
    logic             flt_q;

    assign thr_eff = (i_thr == '0) ? FLT_W'(1) : i_thr;

    // consecutive high cycles
    always_comb begin
        if (!i_fault_raw) begin
            cnt_nxt = '0;
        end else if (cnt_q == '1) begin
            cnt_nxt = cnt_q;    // saturate
        end else begin
            cnt_nxt = cnt_q + FLT_W'(1);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cnt_q <= '0;
            flt_q <= 1'b0;
        end else begin
            cnt_q <= cnt_nxt;
            flt_q <= i_fault_raw && (cnt_nxt >= thr_eff);
        end
    end

    assign o_fault = flt_q;

endmodule

`default_nettype wire

//--- lv_pkg.sv
// register map and state codes assume the 4-bit address, 8-bit data register bus
`default_nettype none

package lv_pkg;

    //====================
    // bus and datapath widths
    //====================
    localparam int REG_AW      = 4;
    localparam int REG_DW      = 8;
    localparam int FLT_W       = 4;    // filter threshold and counter
    localparam int SYNC_STAGES = 2;
    localparam int MODE_W      = 3;
    localparam int IO_ST_W     = 4;    // live pin group in STATUS2

    //====================
    // register map
    //====================
    localparam logic [REG_AW-1:0] ADDR_MODE     = 4'd0;
    localparam logic [REG_AW-1:0] ADDR_CONFIG   = 4'd1;    // CFG_ST only
    localparam logic [REG_AW-1:0] ADDR_ERR_MASK = 4'd2;    // CFG_ST only
    localparam logic [REG_AW-1:0] ADDR_STATUS1  = 4'd3;    // sticky, w1c
    localparam logic [REG_AW-1:0] ADDR_STATUS2  = 4'd4;    // read only
    localparam logic [REG_AW-1:0] ADDR_STATUS3  = 4'd5;    // read only

    // mode register bits
    localparam int MODE_NML = 0;
    localparam int MODE_CFG = 1;
    localparam int MODE_RST = 2;    // self-clearing

    // STATUS1 error bits
    localparam int ERR_ACC = 0;
    localparam int ERR_DT  = 1;
    localparam int ERR_MM  = 2;
    localparam int ERR_UV  = 3;
    localparam int ERR_OV  = 4;
    localparam int ERR_NUM = 5;

    localparam int DEF_FLT_THR = 4;

    // operating states, code 0 unused
    typedef enum logic [2:0] {
        WAIT_ST = 3'd1,
        CFG_ST  = 3'd2,
        NML_ST  = 3'd3,
        FSF_ST  = 3'd4
    } ctrl_st_e;

endpackage

`default_nettype wire

//--- lv_reg_slv.sv
// one request per ack with no back-pressure; rdata is valid only in the ack cycle
`timescale 1ns/10ps
`default_nettype none

module lv_reg_slv #(
    parameter int REG_AW = lv_pkg::REG_AW,
    parameter int REG_DW = lv_pkg::REG_DW,
    parameter int FLT_W  = lv_pkg::FLT_W
)(
    input  logic                       i_clk,
    input  logic                       i_reset,

    input  logic                       i_reg_wr_req,
    input  logic                       i_reg_rd_req,
    input  logic [REG_AW-1:0]          i_reg_addr,
    input  logic [REG_DW-1:0]          i_reg_wdata,
    output logic                       o_reg_ack,
    output logic [REG_DW-1:0]          o_reg_rdata,

    input  logic [lv_pkg::ERR_NUM-1:0] i_err_set,
    input  logic [lv_pkg::IO_ST_W-1:0] i_io_status,
    input  lv_pkg::ctrl_st_e           i_cur_st,

    output logic [FLT_W-1:0]           o_flt_thr,
    output logic                       o_nml_en,
    output logic                       o_cfg_en,
    output logic                       o_rst_en,
    output logic                       o_fault,
    output logic                       o_intb_n
);

    import lv_pkg::*;

    logic [MODE_W-1:0]  mode_q;
    logic [FLT_W-1:0]   thr_q;
    logic [ERR_NUM-1:0] mask_q;
    logic [ERR_NUM-1:0] status1_q;
    logic [ERR_NUM-1:0] status1_set;
    logic [ERR_NUM-1:0] status1_clr;
    logic               ack_q;
    logic [REG_DW-1:0]  rdata_q;
    logic [REG_DW-1:0]  rd_mux;
    logic               addr_hit;
    logic               acc_err;
    logic               cfg_open;
    logic               intb_n_q;

    //====================
    // address decode
    //====================
    always_comb begin
        addr_hit = 1'b1;
        rd_mux   = '0;
        case (i_reg_addr)
            ADDR_MODE:     rd_mux = REG_DW'(mode_q);
            ADDR_CONFIG:   rd_mux = REG_DW'(thr_q);
            ADDR_ERR_MASK: rd_mux = REG_DW'(mask_q);
            ADDR_STATUS1:  rd_mux = REG_DW'(status1_q);
            ADDR_STATUS2:  rd_mux = REG_DW'(i_io_status);
            ADDR_STATUS3:  rd_mux = REG_DW'(i_cur_st);
            default:       addr_hit = 1'b0;    // unmapped reads as 0
        endcase
    end

    assign acc_err  = (i_reg_wr_req || i_reg_rd_req) && !addr_hit;
    assign cfg_open = (i_cur_st == CFG_ST);

    // set wins over a same-cycle clear
    always_comb begin
        status1_set          = i_err_set;
        status1_set[ERR_ACC] = i_err_set[ERR_ACC] | acc_err;
        status1_clr          = '0;
        if (i_reg_wr_req && (i_reg_addr == ADDR_STATUS1)) begin
            status1_clr = i_reg_wdata[ERR_NUM-1:0];
        end
    end

    //====================
    // registers
    //====================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            mode_q    <= '0;
            thr_q     <= FLT_W'(DEF_FLT_THR);
            mask_q    <= '0;
            status1_q <= '0;
            ack_q     <= 1'b0;
            intb_n_q  <= 1'b1;
        end else begin
            ack_q     <= i_reg_wr_req || i_reg_rd_req;
            status1_q <= (status1_q & ~status1_clr) | status1_set;
            intb_n_q  <= ~(|status1_q);

            if (i_reg_wr_req && (i_reg_addr == ADDR_MODE)) begin
                mode_q <= i_reg_wdata[MODE_W-1:0];
            end else begin
                mode_q[MODE_RST] <= 1'b0;    // reset_en lasts one cycle
            end

            // protected outside CFG_ST, silently dropped
            if (i_reg_wr_req && cfg_open && (i_reg_addr == ADDR_CONFIG)) begin
                thr_q <= i_reg_wdata[FLT_W-1:0];
            end
            if (i_reg_wr_req && cfg_open && (i_reg_addr == ADDR_ERR_MASK)) begin
                mask_q <= i_reg_wdata[ERR_NUM-1:0];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reg_rd_req) begin
            rdata_q <= rd_mux;
        end
    end

    assign o_reg_ack   = ack_q;
    assign o_reg_rdata = rdata_q;

    assign o_flt_thr = thr_q;
    assign o_nml_en  = mode_q[MODE_NML];
    assign o_cfg_en  = mode_q[MODE_CFG];
    assign o_rst_en  = mode_q[MODE_RST];

    assign o_fault  = |(status1_q & ~mask_q);    // unmasked errors only
    assign o_intb_n = intb_n_q;

endmodule

`default_nettype wire

//--- tb_lv_core.sv
// reads lv_core_input.txt relative to the working directory, so run from the project root
`timescale 1ns/10ps
`default_nettype none

module tb_lv_core;

    import lv_pkg::*;

    localparam string      DATA_FILE = "lv_core_input.txt";
    localparam int         ACK_WAIT  = 4;        // cycles allowed for o_reg_ack
    localparam logic [7:0] PIN_IDLE  = 8'h88;    // uv_n and fsenb_n high

    logic              i_clk = 1'b0;
    logic              i_reset;
    logic              i_reg_wr_req;
    logic              i_reg_rd_req;
    logic [REG_AW-1:0] i_reg_addr;
    logic [REG_DW-1:0] i_reg_wdata;
    logic              o_reg_ack;
    logic [REG_DW-1:0] o_reg_rdata;
    logic              i_lv_pwm_dt;
    logic              i_lv_gate_vs_pwm;
    logic              i_lv_vsup_ov;
    logic              i_lv_vsup_uv_n;
    logic              i_io_pwm;
    logic              i_io_pwma;
    logic              i_io_fsstate;
    logic              i_io_fsenb_n;
    logic              o_dgt_ang_pwm_en;
    logic              o_dgt_ang_fsc_en;
    logic              o_intb_n;

    int    mismatches   = 0;
    int    checks       = 0;
    int    tests_pass   = 0;
    int    tests_fail   = 0;
    int    test_start   = 0;
    int    limit_cycles = 0;
    bit    stop_run     = 1'b0;
    string cur_test     = "";

    lv_core lv_core_inst (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_reg_wr_req     (i_reg_wr_req),
        .i_reg_rd_req     (i_reg_rd_req),
        .i_reg_addr       (i_reg_addr),
        .i_reg_wdata      (i_reg_wdata),
        .o_reg_ack        (o_reg_ack),
        .o_reg_rdata      (o_reg_rdata),
        .i_lv_pwm_dt      (i_lv_pwm_dt),
        .i_lv_gate_vs_pwm (i_lv_gate_vs_pwm),
        .i_lv_vsup_ov     (i_lv_vsup_ov),
        .i_lv_vsup_uv_n   (i_lv_vsup_uv_n),
        .i_io_pwm         (i_io_pwm),
        .i_io_pwma        (i_io_pwma),
        .i_io_fsstate     (i_io_fsstate),
        .i_io_fsenb_n     (i_io_fsenb_n),
        .o_dgt_ang_pwm_en (o_dgt_ang_pwm_en),
        .o_dgt_ang_fsc_en (o_dgt_ang_fsc_en),
        .o_intb_n         (o_intb_n)
    );

    always #5 i_clk = ~i_clk;

    // ====================
    // helpers
    // ====================
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, what, expected, actual);
        end
    endtask

    // pin vector bits 7..0 are uv_n ov gate_vs_pwm pwm_dt fsenb_n fsstate pwma pwm
    task automatic set_pins(input logic [7:0] pins);
        i_io_pwm         = pins[0];
        i_io_pwma        = pins[1];
        i_io_fsstate     = pins[2];
        i_io_fsenb_n     = pins[3];
        i_lv_pwm_dt      = pins[4];
        i_lv_gate_vs_pwm = pins[5];
        i_lv_vsup_ov     = pins[6];
        i_lv_vsup_uv_n   = pins[7];
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic reg_access(input logic is_wr, input logic [REG_AW-1:0] addr,
                              input logic [REG_DW-1:0] wdata, output logic [REG_DW-1:0] rdata);
        int waited;
        waited       = 1;
        rdata        = '0;
        i_reg_wr_req = is_wr;
        i_reg_rd_req = !is_wr;
        i_reg_addr   = addr;
        i_reg_wdata  = wdata;
        @(negedge i_clk);
        i_reg_wr_req = 1'b0;
        i_reg_rd_req = 1'b0;
        while (!o_reg_ack && waited < ACK_WAIT) begin
            @(negedge i_clk);
            waited++;
        end
        if (!o_reg_ack) begin
            mismatches++;
            stop_run = 1'b1;
            $display("no acknowledge within %0d cycles for access to address %0h at %0t ns",
                     ACK_WAIT, addr, $time);
        end else begin
            rdata = o_reg_rdata;
            @(negedge i_clk);    // bus idle one cycle
            check_value(32'(o_reg_ack), 32'd0, "o_reg_ack one cycle after the acknowledge");
        end
    endtask

    task automatic close_test();
        if (cur_test != "") begin
            if (mismatches == test_start) begin
                tests_pass++;
                $display("test %s: passed", cur_test);
            end else begin
                tests_fail++;
                $display("test %s: failed, %0d mismatches", cur_test, mismatches - test_start);
            end
        end
    endtask

    task automatic apply_reset();
        cur_test   = "reset_outputs";
        test_start = mismatches;
        i_reset    = 1'b1;
        repeat (5) @(posedge i_clk);
        @(negedge i_clk);
        check_value(32'(o_reg_ack), 32'd0, "o_reg_ack in reset");
        check_value(32'(o_dgt_ang_pwm_en), 32'd0, "pwm_en in reset");
        check_value(32'(o_dgt_ang_fsc_en), 32'd0, "fsc_en in reset");
        check_value(32'(o_intb_n), 32'd1, "intb_n in reset");
        i_reset = 1'b0;
    endtask

    // ====================
    // command interpreter
    // ====================
    task automatic run_file();
        int                fd;
        int                rc;
        logic [7:0]        op_ch;
        logic [31:0]       f1;
        logic [31:0]       f2;
        logic [31:0]       f3;
        logic [REG_DW-1:0] rdata;
        logic [8*32-1:0]   name_buf;
        logic [8*128-1:0]  skip_buf;
        fd = $fopen(DATA_FILE, "r");
        while (!stop_run) begin
            rc = $fscanf(fd, " %c", op_ch);
            if (rc != 1) begin
                stop_run = 1'b1;    // end of file
            end else begin
                case (op_ch)
                    "#": rc = $fgets(skip_buf, fd);
                    "T": begin
                        rc = $fscanf(fd, "%s", name_buf);
                        close_test();
                        cur_test   = $sformatf("%0s", name_buf);
                        test_start = mismatches;
                    end
                    "W": begin
                        rc = $fscanf(fd, "%h %h", f1, f2);
                        reg_access(1'b1, f1[REG_AW-1:0], f2[REG_DW-1:0], rdata);
                    end
                    "R": begin
                        rc = $fscanf(fd, "%h %h", f1, f2);
                        reg_access(1'b0, f1[REG_AW-1:0], '0, rdata);
                        check_value(32'(rdata), f2, $sformatf("read of address %0h", f1));
                    end
                    "P": begin
                        rc = $fscanf(fd, "%h", f1);
                        set_pins(f1[7:0]);
                    end
                    "D": begin
                        rc = $fscanf(fd, "%h", f1);
                        repeat (f1) @(negedge i_clk);
                    end
                    "O": begin
                        rc = $fscanf(fd, "%h %h %h", f1, f2, f3);
                        check_value(32'(o_dgt_ang_pwm_en), 32'(f1[0]), "o_dgt_ang_pwm_en");
                        check_value(32'(o_dgt_ang_fsc_en), 32'(f2[0]), "o_dgt_ang_fsc_en");
                        check_value(32'(o_intb_n), 32'(f3[0]), "o_intb_n");
                    end
                    default: begin
                        mismatches++;
                        stop_run = 1'b1;
                        $display("unknown operation %c in %s", op_ch, DATA_FILE);
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    initial begin : main
        int fd;
        int ch;
        int n_lines;
        n_lines      = 0;
        i_reset      = 1'b1;
        i_reg_wr_req = 1'b0;
        i_reg_rd_req = 1'b0;
        i_reg_addr   = '0;
        i_reg_wdata  = '0;
        set_pins(PIN_IDLE);
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s for reading", DATA_FILE);
            $display("ERRORS FOUND");
            $finish;
        end else begin
            ch = $fgetc(fd);
            while (ch != -1) begin
                if (ch == 10) begin
                    n_lines++;
                end
                ch = $fgetc(fd);
            end
            $fclose(fd);
            limit_cycles = 20 * n_lines + 200;
            apply_reset();
            run_file();
            close_test();
            $display("tests passed %0d, failed %0d, checks %0d, mismatches %0d",
                     tests_pass, tests_fail, checks, mismatches);
            if (mismatches == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge i_clk);
        $display("timeout, run still busy after %0d cycles", limit_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
